/* verilog/ahb_ram_pkg.sv */
//**************************************************************************
// Sizes fixed for a 16 KB RAM on a 32-bit AHB-Lite bus
// Transfers wider than a word are treated as word transfers
//**************************************************************************

package ahb_ram_pkg;

   // Memory geometry
   localparam int ram_addr_w = 14;               // Byte address bits on haddr
   localparam int ram_word_w = ram_addr_w - 2;   // Word index bits
   localparam int ram_depth  = 4096;             // 32-bit words
   localparam int data_w     = 32;               // AHB data bus
   localparam int lane_n     = data_w / 8;       // Byte lanes per word

   // Only OKAY is ever returned
   localparam logic hresp_okay = 1'b0;

   // HTRANS encodings
   typedef enum logic [1:0] {
      trans_idle   = 2'b00,
      trans_busy   = 2'b01,
      trans_nonseq = 2'b10,
      trans_seq    = 2'b11
   } htrans_e;

   // HSIZE encodings, byte to word only
   typedef enum logic [2:0] {
      size_byte = 3'b000,
      size_half = 3'b001,
      size_word = 3'b010
   } hsize_e;

   // Byte lanes touched by a transfer, little endian
   function automatic logic [lane_n-1:0] lane_mask(
      input hsize_e     size,
      input logic [1:0] addr_lo
   );
      logic [lane_n-1:0] mask;
      case (size)
         size_byte: mask = 4'b0001 << addr_lo;   // One lane at the byte offset
         size_half: begin
            // Halfword picks lower or upper pair
            mask = addr_lo[1] ? 4'b1100 : 4'b0011;
         end
         default:   mask = 4'b1111;              // Word and anything wider
      endcase
      return mask;
   endfunction

endpackage

/* verilog/ahb_xfer_decode.sv */
//**************************************************************************
// Address phase only counts with hsel, hready and NONSEQ/SEQ all present
// Data-phase info is held while hready is low
//**************************************************************************

`timescale 1ns/1ps

module ahb_xfer_decode (
   input  logic                                hclk,
   input  logic                                arst_n,
   input  logic                                hsel,
   input  logic [ahb_ram_pkg::ram_addr_w-1:0]  haddr,
   input  ahb_ram_pkg::htrans_e                htrans,
   input  ahb_ram_pkg::hsize_e                 hsize,
   input  logic                                hwrite,
   input  logic                                hready,
   output logic                                rd_en,      // Read in this address phase
   output logic [ahb_ram_pkg::ram_word_w-1:0]  rd_word,    // Word for that read
   output logic [ahb_ram_pkg::ram_word_w-1:0]  wr_word,    // Word in write data phase
   output logic [ahb_ram_pkg::lane_n-1:0]      wr_lanes,   // Lanes to write, zero if none
   output logic                                rd_pending  // Read in data phase
);

   import ahb_ram_pkg::*;

   logic              active;     // NONSEQ or SEQ
   logic              accept;     // Address phase taken this edge
   logic [lane_n-1:0] lanes;      // Lanes of the current address phase

   // IDLE and BUSY carry no transfer
   assign active = (htrans == trans_nonseq) || (htrans == trans_seq);
   assign accept = hsel & hready & active;

   assign lanes = lane_mask(hsize, haddr[1:0]);

   // Read path goes straight to the RAM so data lands in the data phase
   assign rd_en   = accept & ~hwrite;
   assign rd_word = haddr[ram_addr_w-1:2];

   // Data-phase control
   // Only moves on edges where the bus advances
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_lanes   <= '0;
         rd_pending <= 1'b0;
      end else if (hready) begin
         if (accept && hwrite) begin
            wr_lanes <= lanes;
         end else begin
            wr_lanes <= '0;                  // Read or no transfer
         end
         rd_pending <= accept & ~hwrite;
      end
   end

   // Write word index, payload only
   always_ff @(posedge hclk) begin
      if (accept && hwrite) begin
         wr_word <= haddr[ram_addr_w-1:2];   // Held until next write
      end
   end

endmodule

/* verilog/bytewrite_ram.sv */
//**************************************************************************
// Read-first block RAM, contents undefined after power-up
//**************************************************************************

`timescale 1ns/1ps

module bytewrite_ram (
   input  logic                                hclk,
   input  logic                                rd_en,
   input  logic [ahb_ram_pkg::ram_word_w-1:0]  rd_word,
   input  logic [ahb_ram_pkg::ram_word_w-1:0]  wr_word,
   input  logic [ahb_ram_pkg::lane_n-1:0]      wr_lanes,
   input  logic [ahb_ram_pkg::data_w-1:0]      din,
   output logic [ahb_ram_pkg::data_w-1:0]      dout
);

   import ahb_ram_pkg::*;

   logic [data_w-1:0] mem [ram_depth];   // Word array

   // One enable per byte lane
   // A write of zero lanes leaves the word alone
   always_ff @(posedge hclk) begin
      for (int i = 0; i < lane_n; i++) begin
         if (wr_lanes[i]) begin
            mem[wr_word][8*i +: 8] <= din[8*i +: 8];
         end
      end
   end

   // Registered read
   // Same-edge write to the same word gives old data here
   always_ff @(posedge hclk) begin
      if (rd_en) begin
         dout <= mem[rd_word];   // Held between reads
      end
   end

endmodule

/* verilog/ahb_read_merge.sv */
//**************************************************************************
// Forwards bytes of a write whose data phase overlaps a read address phase
// Never stalls, response is always OKAY
//**************************************************************************

`timescale 1ns/1ps

module ahb_read_merge (
   input  logic                                hclk,
   input  logic                                arst_n,
   input  logic [ahb_ram_pkg::ram_word_w-1:0]  rd_word,
   input  logic                                rd_en,
   input  logic [ahb_ram_pkg::ram_word_w-1:0]  wr_word,
   input  logic [ahb_ram_pkg::lane_n-1:0]      wr_lanes,
   input  logic [ahb_ram_pkg::data_w-1:0]      hwdata,
   input  logic [ahb_ram_pkg::data_w-1:0]      dout,
   input  logic                                rd_pending,
   output logic [ahb_ram_pkg::data_w-1:0]      hrdata,
   output logic                                hreadyout,
   output logic                                hresp
);

   import ahb_ram_pkg::*;

   logic              hit;         // Read word equals word being written
   logic              fwd_hit;     // Registered hit for the read data phase
   logic [lane_n-1:0] fwd_lanes;   // Lanes written under the read
   logic [data_w-1:0] fwd_data;    // Their write data

   // Write data phase and read address phase on the same word
   assign hit = (rd_word == wr_word) && (wr_lanes != '0);

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         fwd_hit <= 1'b0;
      end else if (rd_en) begin
         fwd_hit <= hit;             // Kept until next read
      end
   end

   // Forward payload, captured alongside the RAM read
   always_ff @(posedge hclk) begin
      if (rd_en) begin
         fwd_lanes <= wr_lanes;
         fwd_data  <= hwdata;
      end
   end

   // Lane by lane merge of new bytes over RAM data
   always_comb begin
      for (int i = 0; i < lane_n; i++) begin
         if (rd_pending && fwd_hit && fwd_lanes[i]) begin
            hrdata[8*i +: 8] = fwd_data[8*i +: 8];   // Newly written byte
         end else begin
            hrdata[8*i +: 8] = dout[8*i +: 8];
         end
      end
   end

   // Zero wait states
   assign hreadyout = 1'b1;
   assign hresp     = hresp_okay;

endmodule

/* verilog/ahb_ram.sv */
//**************************************************************************
// Zero-wait AHB-Lite RAM slave, 16 KB, byte/half/word writes
// No ROM mode, no error responses
//**************************************************************************

`timescale 1ns/1ps

module ahb_ram (
   input  logic                                hclk,
   input  logic                                arst_n,
   input  logic                                hsel,
   input  logic [ahb_ram_pkg::ram_addr_w-1:0]  haddr,
   input  ahb_ram_pkg::htrans_e                htrans,
   input  ahb_ram_pkg::hsize_e                 hsize,
   input  logic                                hwrite,
   input  logic [ahb_ram_pkg::data_w-1:0]      hwdata,
   input  logic                                hready,
   output logic                                hreadyout,
   output logic [ahb_ram_pkg::data_w-1:0]      hrdata,
   output logic                                hresp
);

   import ahb_ram_pkg::*;

   logic                  rd_en;        // Read address phase accepted
   logic [ram_word_w-1:0] rd_word;
   logic [ram_word_w-1:0] wr_word;      // Write data phase word
   logic [lane_n-1:0]     wr_lanes;
   logic                  rd_pending;   // Read data phase
   logic [data_w-1:0]     ram_dout;     // Old RAM contents

   // Address phase capture and lane decode
   ahb_xfer_decode u_decode (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .hsel       (hsel),
      .haddr      (haddr),
      .htrans     (htrans),
      .hsize      (hsize),
      .hwrite     (hwrite),
      .hready     (hready),
      .rd_en      (rd_en),
      .rd_word    (rd_word),
      .wr_word    (wr_word),
      .wr_lanes   (wr_lanes),
      .rd_pending (rd_pending)
   );

   // hwdata goes straight to the array in the write data phase
   bytewrite_ram u_ram (
      .hclk     (hclk),
      .rd_en    (rd_en),
      .rd_word  (rd_word),
      .wr_word  (wr_word),
      .wr_lanes (wr_lanes),
      .din      (hwdata),
      .dout     (ram_dout)
   );

   ahb_read_merge u_merge (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .rd_word    (rd_word),
      .rd_en      (rd_en),
      .wr_word    (wr_word),
      .wr_lanes   (wr_lanes),
      .hwdata     (hwdata),
      .dout       (ram_dout),
      .rd_pending (rd_pending),
      .hrdata     (hrdata),
      .hreadyout  (hreadyout),
      .hresp      (hresp)
   );

endmodule

/* bench/ahb_ram_checker.sv */
//**************************************************************************
// Compares only bytes written during the run, unwritten RAM is undefined
// Checks are counted per test and reported on each test_end pulse
//**************************************************************************

`timescale 1ns/1ps

module ahb_ram_checker (
   input  logic                                hclk,
   input  logic                                arst_n,
   input  logic                                hsel,
   input  logic [ahb_ram_pkg::ram_addr_w-1:0]  haddr,
   input  ahb_ram_pkg::htrans_e                htrans,
   input  ahb_ram_pkg::hsize_e                 hsize,
   input  logic                                hwrite,
   input  logic [ahb_ram_pkg::data_w-1:0]      hwdata,
   input  logic                                hready,
   input  logic                                hreadyout,
   input  logic [ahb_ram_pkg::data_w-1:0]      hrdata,
   input  logic                                hresp,
   input  int                                  test_id,
   input  logic                                test_end,
   output int                                  check_total,
   output int                                  err_total
);

   import ahb_ram_pkg::*;

   logic [data_w-1:0]     ref_mem   [ram_depth];
   logic [3:0]            ref_valid [ram_depth];   // Lanes written so far
   logic                  dp_valid;                // Transfer in its data phase
   logic                  dp_write;
   logic [ram_word_w-1:0] dp_word;
   logic [3:0]            dp_lanes;
   int                    test_checks;
   int                    test_errs;

   // Lanes from size and offset, anything wider counts as a word
   function automatic logic [3:0] ref_lanes(input logic [2:0] size, input logic [1:0] lo);
      int         nbytes;
      int         base;
      logic [3:0] m;
      nbytes = (size >= 3'd2) ? 4 : (size + 1);
      base   = (lo / nbytes) * nbytes;   // Aligned start lane
      for (int i = 0; i < 4; i++) begin
         m[i] = (i >= base) && (i < base + nbytes);
      end
      return m;
   endfunction

   // Stored word after a write of some lanes
   function automatic logic [data_w-1:0] apply_write(
      input logic [data_w-1:0] old_word,
      input logic [data_w-1:0] data,
      input logic [3:0]        lanes
   );
      logic [data_w-1:0] w;
      w = old_word;
      for (int i = 0; i < 4; i++) begin
         if (lanes[i]) begin
            w[8*i +: 8] = data[8*i +: 8];
         end
      end
      return w;
   endfunction

   // Bit mask of the lanes that hold known data
   function automatic logic [data_w-1:0] known_bits(input logic [3:0] lanes);
      logic [data_w-1:0] m;
      for (int i = 0; i < 4; i++) begin
         m[8*i +: 8] = {8{lanes[i]}};
      end
      return m;
   endfunction

   task automatic tally_check(input logic ok);
      test_checks++;
      check_total++;
      if (!ok) begin
         test_errs++;
         err_total++;
      end
   endtask

   initial begin
      for (int i = 0; i < ram_depth; i++) begin
         ref_valid[i] = 4'b0000;
      end
      dp_valid    = 1'b0;
      test_checks = 0;
      test_errs   = 0;
      check_total = 0;
      err_total   = 0;
   end

   always @(posedge hclk) begin
      logic [data_w-1:0] m;
      logic [data_w-1:0] exp;
      // Fixed response, also during and right after reset
      tally_check(hreadyout === 1'b1 && hresp === 1'b0);
      if (hreadyout !== 1'b1 || hresp !== 1'b0) begin
         $display("ERROR at %0t: hreadyout=%b hresp=%b, expected 1 and 0",
                  $time, hreadyout, hresp);
      end
      if (!arst_n) begin
         dp_valid = 1'b0;
      end else if (hready) begin
         if (dp_valid && dp_write) begin   // Write lands at end of data phase
            ref_mem[dp_word]   = apply_write(ref_mem[dp_word], hwdata, dp_lanes);
            ref_valid[dp_word] = ref_valid[dp_word] | dp_lanes;
         end else if (dp_valid && ref_valid[dp_word] != 4'b0000) begin
            m   = known_bits(ref_valid[dp_word]);
            exp = ref_mem[dp_word] & m;
            tally_check((hrdata & m) === exp);
            if ((hrdata & m) !== exp) begin
               $display("ERROR at %0t: read addr 0x%h expected 0x%h got 0x%h",
                        $time, {dp_word, 2'b00}, exp, hrdata & m);
            end
         end
         // Address phase taken on this edge
         dp_valid = hsel && htrans[1];
         dp_write = hwrite;
         dp_word  = haddr[ram_addr_w-1:2];
         dp_lanes = ref_lanes(hsize, haddr[1:0]);
      end
      if (test_end) begin
         $display("Test %0d finished: %0d checks, %0d errors", test_id, test_checks,
                  test_errs);
         test_checks = 0;
         test_errs   = 0;
      end
   end

endmodule

/* bench/ahb_ram_tb.sv */
//**************************************************************************
// One master and one slave, with hready stalls standing in for another slave
//**************************************************************************

`timescale 1ns/1ps

module ahb_ram_tb;

   import ahb_ram_pkg::*;

   localparam int n_words = 16;   // Word write then read pairs
   localparam int n_sub   = 12;   // Byte and halfword writes
   localparam int n_fwd   = 12;   // Rounds of write and read pairs, same word then other word
   localparam int n_ign   = 6;    // Rounds of ignored transfers
   localparam int n_stall = 4;    // Rounds with hready low
   localparam int end_len = 4;    // Idle tail and test_end pulse
   localparam int stim_cycles = 8 + (4 + end_len) + (2 * n_words + end_len)
      + (3 * n_sub + end_len) + (4 * n_fwd + end_len) + (4 * n_ign + end_len)
      + (9 * n_stall + end_len) + 1;
   localparam int timeout_cycles = 2 * stim_cycles;

   logic                  hclk = 1'b0;
   logic                  arst_n;
   logic                  hsel;
   logic [ram_addr_w-1:0] haddr;
   htrans_e               htrans;
   hsize_e                hsize;
   logic                  hwrite;
   logic [data_w-1:0]     hwdata;
   logic                  hready;
   logic                  hreadyout;
   logic [data_w-1:0]     hrdata;
   logic                  hresp;
   int                    test_id;
   logic                  test_end;
   int                    check_total;
   int                    err_total;
   integer                seed;
   int                    cycles = 0;
   logic [data_w-1:0]     pend_data;   // hwdata for the next data phase
   logic [ram_word_w-1:0] words [n_words];

   always #5 hclk = ~hclk;

   ahb_ram ahb_ram_i (
      .hclk(hclk), .arst_n(arst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
      .hsize(hsize), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
      .hreadyout(hreadyout), .hrdata(hrdata), .hresp(hresp)
   );

   ahb_ram_checker u_check (
      .hclk(hclk), .arst_n(arst_n), .hsel(hsel), .haddr(haddr), .htrans(htrans),
      .hsize(hsize), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
      .hreadyout(hreadyout), .hrdata(hrdata), .hresp(hresp), .test_id(test_id),
      .test_end(test_end), .check_total(check_total), .err_total(err_total)
   );

   // Address phase of one transfer with the data phase of the one before
   task automatic drive_phase(input logic sel, input htrans_e trans, input hsize_e size,
                              input logic wr, input logic [ram_addr_w-1:0] addr,
                              input logic [data_w-1:0] data);
      @(posedge hclk);
      hsel      <= sel;
      htrans    <= trans;
      hsize     <= size;
      hwrite    <= wr;
      haddr     <= addr;
      hready    <= 1'b1;
      hwdata    <= pend_data;
      pend_data = data;
   endtask

   task automatic write_xfer(input hsize_e size, input logic [ram_addr_w-1:0] addr);
      drive_phase(1'b1, trans_nonseq, size, 1'b1, addr, $random(seed));
   endtask

   task automatic read_xfer(input logic [ram_word_w-1:0] w);
      drive_phase(1'b1, trans_nonseq, size_word, 1'b0, {w, 2'b00}, $random(seed));
   endtask

   task automatic idle_phase();
      drive_phase(1'b1, trans_idle, size_word, 1'b0, '0, $random(seed));
   endtask

   // hready low while a write to another word waits on the bus
   task automatic stall_bus(input int n, input logic [ram_word_w-1:0] w);
      repeat (n) begin
         @(posedge hclk);
         hready <= 1'b0;
         hsel   <= 1'b1;
         htrans <= trans_nonseq;
         hsize  <= size_word;
         hwrite <= 1'b1;
         haddr  <= {w, 2'b00};
         hwdata <= pend_data;   // Held data phase keeps its data
      end
   endtask

   // Random size with an offset aligned to it
   task automatic rand_xfer(input logic [ram_word_w-1:0] w, input logic sub_only,
                            output hsize_e size, output logic [ram_addr_w-1:0] addr);
      logic [1:0] off;
      size = hsize_e'($unsigned($random(seed)) % (sub_only ? 2 : 3));
      off  = 2'($unsigned($random(seed)) % 4);
      if (size == size_half) begin
         off[0] = 1'b0;
      end else if (size == size_word) begin
         off = 2'b00;
      end
      addr = {w, off};
   endtask

   task automatic end_test(input int id);
      idle_phase();
      idle_phase();   // Last data phase done
      @(posedge hclk);
      test_id  <= id;
      test_end <= 1'b1;
      @(posedge hclk);
      test_end <= 1'b0;
   endtask

   initial begin
      int                    k;
      hsize_e                size;
      logic [ram_addr_w-1:0] addr;
      seed      = 83;
      arst_n    = 1'b0;
      hsel      = 1'b0;
      haddr     = '0;
      htrans    = trans_idle;
      hsize     = size_word;
      hwrite    = 1'b0;
      hwdata    = '0;
      hready    = 1'b1;
      test_id   = 0;
      test_end  = 1'b0;
      pend_data = '0;
      repeat (8) @(posedge hclk);
      arst_n <= 1'b1;
      repeat (4) idle_phase();   // Response out of reset
      end_test(1);
      for (k = 0; k < n_words; k++) begin
         words[k] = ram_word_w'($random(seed));
         write_xfer(size_word, {words[k], 2'b00});
      end
      for (k = 0; k < n_words; k++) begin
         read_xfer(words[k]);
      end
      end_test(2);
      for (k = 0; k < n_sub; k++) begin
         rand_xfer(words[k], 1'b1, size, addr);
         write_xfer(size, addr);
         idle_phase();           // Gap so the read is not forwarded
         read_xfer(words[k]);
      end
      end_test(3);
      for (k = 0; k < n_fwd; k++) begin
         rand_xfer(words[k], 1'b0, size, addr);
         write_xfer(size, addr);
         read_xfer(words[k]);    // Hits the write data phase
         rand_xfer(words[(k + 1) % n_words], 1'b0, size, addr);
         write_xfer(size, addr);
         read_xfer(words[k]);    // Other word in its data phase
      end
      end_test(4);
      for (k = 0; k < n_ign; k++) begin
         drive_phase(1'b0, trans_nonseq, size_word, 1'b1, {words[k], 2'b00}, $random(seed));
         drive_phase(1'b1, trans_idle, size_word, 1'b1, {words[k], 2'b00}, $random(seed));
         drive_phase(1'b1, trans_busy, size_word, 1'b1, {words[k], 2'b00}, $random(seed));
         drive_phase(1'b1, trans_seq, size_word, 1'b0, {words[k], 2'b00}, $random(seed));
      end
      end_test(5);
      for (k = 0; k < n_stall; k++) begin
         write_xfer(size_word, {words[k + n_ign], 2'b00});
         stall_bus(3, words[n_words - 1 - k]);   // Write held in data phase
         read_xfer(words[k + n_ign]);
         read_xfer(words[n_words - 1 - k]);
         stall_bus(2, words[n_words - 1 - k]);   // Read held in data phase
         idle_phase();
      end
      end_test(6);
      @(negedge hclk);
      $display("All tests: %0d checks, %0d errors", check_total, err_total);
      if (err_total == 0 && check_total > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   always @(posedge hclk) begin
      cycles++;
      if (cycles > timeout_cycles) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

endmodule

/* build.f */
verilog/ahb_ram_pkg.sv
verilog/ahb_xfer_decode.sv
verilog/bytewrite_ram.sv
verilog/ahb_read_merge.sv
verilog/ahb_ram.sv
bench/ahb_ram_checker.sv
bench/ahb_ram_tb.sv

/* Bender.yml */
package:
  name: ahb_ram

sources:
  - verilog/ahb_ram_pkg.sv
  - verilog/ahb_xfer_decode.sv
  - verilog/bytewrite_ram.sv
  - verilog/ahb_read_merge.sv
  - verilog/ahb_ram.sv
  - target: test
    files:
      - bench/ahb_ram_checker.sv
      - bench/ahb_ram_tb.sv
